//--- logic/csr_addr_pkg.sv
`default_nettype none

package csr_addr_pkg;

    localparam int CSR_NUM_W = 14;

    localparam logic [CSR_NUM_W-1:0] CSR_CRMD      = 14'h000;
    localparam logic [CSR_NUM_W-1:0] CSR_PRMD      = 14'h001;
    localparam logic [CSR_NUM_W-1:0] CSR_ECFG      = 14'h004;
    localparam logic [CSR_NUM_W-1:0] CSR_ESTAT     = 14'h005;
    localparam logic [CSR_NUM_W-1:0] CSR_ERA       = 14'h006;
    localparam logic [CSR_NUM_W-1:0] CSR_BADV      = 14'h007;
    localparam logic [CSR_NUM_W-1:0] CSR_EENTRY    = 14'h00C;
    localparam logic [CSR_NUM_W-1:0] CSR_SAVE_BASE = 14'h030; // SAVE0, others follow
    localparam logic [CSR_NUM_W-1:0] CSR_TCFG      = 14'h041;
    localparam logic [CSR_NUM_W-1:0] CSR_TVAL      = 14'h042;
    localparam logic [CSR_NUM_W-1:0] CSR_TICLR     = 14'h044;

    localparam int CRMD_IE_BIT       = 2;
    localparam int PRMD_PIE_BIT      = 2;
    localparam int EENTRY_VA_LSB     = 6;
    localparam int TCFG_EN_BIT       = 0;
    localparam int TCFG_PERIODIC_BIT = 1;
    localparam int TCFG_INITVAL_LSB  = 2;
    localparam int TICLR_CLR_BIT     = 0;

    localparam logic [12:0] ECFG_LIE_MASK = 13'h1BFF; // Bit 10 not implemented

    localparam logic [5:0] ECODE_ADE     = 6'h08;
    localparam logic [5:0] ECODE_ALE     = 6'h09;
    localparam logic [8:0] ESUBCODE_ADEF = 9'h000;

    localparam int IRQ_TIMER = 11;
    localparam int IRQ_IPI   = 12;

endpackage

`default_nettype wire

//--- logic/csr_types_pkg.sv
`default_nettype none

package csr_types_pkg;

    typedef struct packed {
        logic                                 we;
        logic [csr_addr_pkg::CSR_NUM_W-1:0]   num;
        logic [31:0]                          wmask;
        logic [31:0]                          wvalue;
    } csr_write_t;

    // Report of the instruction leaving writeback
    typedef struct packed {
        logic        ex;
        logic        ertn;
        logic [31:0] pc;
        logic [5:0]  ecode;
        logic [8:0]  esubcode;
        logic [31:0] vaddr;
    } trap_event_t;

    typedef struct packed {
        logic [7:0] hw;
        logic       ipi;
    } irq_lines_t;

    typedef struct packed {
        logic [1:0]  plv;
        logic        ie;
        logic [1:0]  pplv;
        logic        pie;
        logic [31:0] era;
        logic [5:0]  ecode;
        logic [8:0]  esubcode;
        logic [31:0] badv;
        logic [25:0] eentry_va;
    } trap_regs_t;

    typedef struct packed {
        logic [12:0] lie;
        logic [12:0] is;
    } irq_regs_t;

    typedef struct packed {
        logic        en;
        logic        periodic;
        logic [29:0] initval;
        logic [31:0] tval;
    } timer_regs_t;

    function automatic logic [31:0] masked_merge(input logic [31:0] old,
                                                 input csr_write_t  wr);
        return (wr.wmask & wr.wvalue) | (~wr.wmask & old);
    endfunction

endpackage

`default_nettype wire

//--- logic/trap_state.sv
`default_nettype none
`timescale 1ns/1ps

module trap_state (
    input  wire                         clk,
    input  wire                         reset,
    input  wire csr_types_pkg::csr_write_t  wr,
    input  wire csr_types_pkg::trap_event_t trap,
    output csr_types_pkg::trap_regs_t   regs,
    output logic [31:0]                 ex_entry,
    output logic [31:0]                 ertn_entry
);
    import csr_addr_pkg::*;
    import csr_types_pkg::*;

    logic [1:0]  plv;
    logic        ie;
    logic [1:0]  pplv;
    logic        pie;
    logic [31:0] era;
    logic [5:0]  ecode;
    logic [8:0]  esubcode;
    logic [31:0] badv;
    logic [25:0] eentry_va;
    logic        sw_we;
    logic        addr_err;
    logic [31:0] crmd_new;
    logic [31:0] prmd_new;
    logic [31:0] era_new;
    logic [31:0] eentry_new;

    assign sw_we    = wr.we && !trap.ex && !trap.ertn; // Traps win over software
    assign addr_err = trap.ecode == ECODE_ADE || trap.ecode == ECODE_ALE;

    assign crmd_new   = masked_merge({29'b0, ie, plv}, wr);
    assign prmd_new   = masked_merge({29'b0, pie, pplv}, wr);
    assign era_new    = masked_merge(era, wr);
    assign eentry_new = masked_merge({eentry_va, 6'b0}, wr);

    always_ff @(posedge clk) begin
        if (reset) begin
            plv      <= 2'b0;
            ie       <= 1'b0;
            ecode    <= 6'b0;
            esubcode <= 9'b0;
        end else if (trap.ex) begin
            plv      <= 2'b0; // Handler runs at PLV0
            ie       <= 1'b0;
            ecode    <= trap.ecode;
            esubcode <= trap.esubcode;
        end else if (trap.ertn) begin
            plv <= pplv;
            ie  <= pie;
        end else if (sw_we && wr.num == CSR_CRMD) begin
            plv <= crmd_new[1:0];
            ie  <= crmd_new[CRMD_IE_BIT];
        end
    end

    always_ff @(posedge clk) begin
        if (trap.ex) begin
            pplv <= plv;
            pie  <= ie;
            era  <= trap.pc;
        end else begin
            if (sw_we && wr.num == CSR_PRMD) begin
                pplv <= prmd_new[1:0];
                pie  <= prmd_new[PRMD_PIE_BIT];
            end
            if (sw_we && wr.num == CSR_ERA)
                era <= era_new;
        end
        if (trap.ex && addr_err)
            badv <= (trap.ecode == ECODE_ADE && trap.esubcode == ESUBCODE_ADEF) ?
                    trap.pc : trap.vaddr; // Fetch fault reports the pc
        if (sw_we && wr.num == CSR_EENTRY)
            eentry_va <= eentry_new[31:EENTRY_VA_LSB];
    end

    assign regs = '{plv: plv, ie: ie, pplv: pplv, pie: pie, era: era, ecode: ecode,
                    esubcode: esubcode, badv: badv, eentry_va: eentry_va};

    assign ex_entry   = {eentry_va, 6'b0};
    assign ertn_entry = era;

endmodule

`default_nettype wire

//--- logic/interrupt_ctrl.sv
`default_nettype none
`timescale 1ns/1ps

module interrupt_ctrl (
    input  wire                        clk,
    input  wire                        reset,
    input  wire csr_types_pkg::csr_write_t wr,
    input  wire csr_types_pkg::irq_lines_t irq,
    input  wire                        ie,
    input  wire                        timer_zero,
    output csr_types_pkg::irq_regs_t   regs,
    output logic                       has_int
);
    import csr_addr_pkg::*;
    import csr_types_pkg::*;

    logic [12:0] lie;
    logic [12:0] estat_is;
    logic [31:0] ecfg_new;
    logic [31:0] estat_new;
    logic        ticlr_hit;

    assign ecfg_new  = masked_merge({19'b0, lie}, wr);
    assign estat_new = masked_merge({19'b0, estat_is}, wr);
    assign ticlr_hit = wr.we && wr.num == CSR_TICLR &&
                       wr.wmask[TICLR_CLR_BIT] && wr.wvalue[TICLR_CLR_BIT];

    always_ff @(posedge clk) begin
        if (reset) begin
            lie      <= 13'b0;
            estat_is <= 13'b0;
        end else begin
            if (wr.we && wr.num == CSR_ECFG)
                lie <= ecfg_new[12:0] & ECFG_LIE_MASK;
            if (wr.we && wr.num == CSR_ESTAT)
                estat_is[1:0] <= estat_new[1:0]; // Software interrupts
            estat_is[9:2] <= irq.hw;
            estat_is[10]  <= 1'b0;
            if (timer_zero)
                estat_is[IRQ_TIMER] <= 1'b1; // Set beats clear
            else if (ticlr_hit)
                estat_is[IRQ_TIMER] <= 1'b0;
            estat_is[IRQ_IPI] <= irq.ipi;
        end
    end

    assign regs    = '{lie: lie, is: estat_is};
    assign has_int = ie && |(estat_is & lie);

endmodule

`default_nettype wire

//--- logic/stable_timer.sv
`default_nettype none
`timescale 1ns/1ps

module stable_timer (
    input  wire                        clk,
    input  wire                        reset,
    input  wire csr_types_pkg::csr_write_t wr,
    output csr_types_pkg::timer_regs_t regs,
    output logic                       timer_zero
);
    import csr_addr_pkg::*;
    import csr_types_pkg::*;

    logic        en;
    logic        periodic;
    logic [29:0] initval;
    logic [31:0] cnt;
    logic [31:0] tcfg_new;
    logic        tcfg_wr;

    assign tcfg_wr  = wr.we && wr.num == CSR_TCFG;
    assign tcfg_new = masked_merge({initval, periodic, en}, wr);

    always_ff @(posedge clk) begin
        if (reset) begin
            en       <= 1'b0;
            periodic <= 1'b0;
            initval  <= 30'b0;
        end else if (tcfg_wr) begin
            en       <= tcfg_new[TCFG_EN_BIT];
            periodic <= tcfg_new[TCFG_PERIODIC_BIT];
            initval  <= tcfg_new[31:TCFG_INITVAL_LSB];
        end
    end

    // Counter counts in units of four cycles of initval
    always_ff @(posedge clk) begin
        if (reset) begin
            cnt <= '1;
        end else if (tcfg_wr && tcfg_new[TCFG_EN_BIT]) begin
            cnt <= {tcfg_new[31:TCFG_INITVAL_LSB], 2'b0};
        end else if (en && cnt != '1) begin
            if (cnt == '0 && periodic)
                cnt <= {initval, 2'b0};
            else
                cnt <= cnt - 32'd1; // One-shot wraps to all ones and halts
        end
    end

    assign timer_zero = cnt == '0;
    assign regs       = '{en: en, periodic: periodic, initval: initval, tval: cnt};

endmodule

`default_nettype wire

//--- logic/save_regs.sv
`default_nettype none
`timescale 1ns/1ps

module save_regs #(
    parameter int SAVE_COUNT = 4
) (
    input  wire                        clk,
    input  wire csr_types_pkg::csr_write_t wr,
    output logic [SAVE_COUNT-1:0][31:0] data
);
    import csr_addr_pkg::*;
    import csr_types_pkg::*;

    // Scratch registers for the trap handler
    always_ff @(posedge clk) begin
        for (int i = 0; i < SAVE_COUNT; i++) begin
            if (wr.we && wr.num == CSR_SAVE_BASE + i)
                data[i] <= masked_merge(data[i], wr);
        end
    end

endmodule

`default_nettype wire

//--- logic/csr_read_mux.sv
`default_nettype none
`timescale 1ns/1ps

module csr_read_mux #(
    parameter int SAVE_COUNT = 4
) (
    input  wire                               csr_re,
    input  wire [csr_addr_pkg::CSR_NUM_W-1:0] csr_num,
    input  wire csr_types_pkg::trap_regs_t    trap_regs,
    input  wire csr_types_pkg::irq_regs_t     irq_regs,
    input  wire csr_types_pkg::timer_regs_t   timer_regs,
    input  wire [SAVE_COUNT-1:0][31:0]        save_data,
    output logic [31:0]                       csr_rvalue
);
    import csr_addr_pkg::*;

    logic [31:0] rdata;

    always_comb begin
        rdata = 32'b0; // Unknown numbers read zero
        case (csr_num)
            CSR_CRMD:   rdata = {28'b0, 1'b1, trap_regs.ie, trap_regs.plv}; // DA set
            CSR_PRMD:   rdata = {29'b0, trap_regs.pie, trap_regs.pplv};
            CSR_ECFG:   rdata = {19'b0, irq_regs.lie};
            CSR_ESTAT:  rdata = {1'b0, trap_regs.esubcode, trap_regs.ecode, 3'b0,
                                 irq_regs.is};
            CSR_ERA:    rdata = trap_regs.era;
            CSR_BADV:   rdata = trap_regs.badv;
            CSR_EENTRY: rdata = {trap_regs.eentry_va, 6'b0};
            CSR_TCFG:   rdata = {timer_regs.initval, timer_regs.periodic, timer_regs.en};
            CSR_TVAL:   rdata = timer_regs.tval;
            CSR_TICLR:  rdata = 32'b0; // Write-only clear
            default: begin
                for (int i = 0; i < SAVE_COUNT; i++) begin
                    if (csr_num == CSR_SAVE_BASE + i)
                        rdata = save_data[i];
                end
            end
        endcase
    end

    assign csr_rvalue = csr_re ? rdata : 32'b0;

endmodule

`default_nettype wire

//--- logic/csr_top.sv
`default_nettype none
`timescale 1ns/1ps

module csr_top #(
    parameter int SAVE_COUNT = 4
) (
    input  wire                               clk,
    input  wire                               reset,
    input  wire csr_types_pkg::csr_write_t    wr,
    input  wire                               csr_re,
    input  wire [csr_addr_pkg::CSR_NUM_W-1:0] csr_num,
    input  wire csr_types_pkg::trap_event_t   trap,
    input  wire csr_types_pkg::irq_lines_t    irq,
    output wire [31:0]                        csr_rvalue,
    output wire                               has_int,
    output wire [31:0]                        ex_entry,
    output wire [31:0]                        ertn_entry
);
    import csr_types_pkg::*;

    wire trap_regs_t            trap_regs;
    wire irq_regs_t             irq_regs;
    wire timer_regs_t           timer_regs;
    wire [SAVE_COUNT-1:0][31:0] save_data;
    wire                        timer_zero;

    trap_state u_trap_state (
        .clk        (clk),
        .reset      (reset),
        .wr         (wr),
        .trap       (trap),
        .regs       (trap_regs),
        .ex_entry   (ex_entry),
        .ertn_entry (ertn_entry)
    );

    interrupt_ctrl u_interrupt_ctrl (
        .clk        (clk),
        .reset      (reset),
        .wr         (wr),
        .irq        (irq),
        .ie         (trap_regs.ie),
        .timer_zero (timer_zero),
        .regs       (irq_regs),
        .has_int    (has_int)
    );

    stable_timer u_stable_timer (
        .clk        (clk),
        .reset      (reset),
        .wr         (wr),
        .regs       (timer_regs),
        .timer_zero (timer_zero)
    );

    save_regs #(.SAVE_COUNT(SAVE_COUNT)) u_save_regs (
        .clk  (clk),
        .wr   (wr),
        .data (save_data)
    );

    csr_read_mux #(.SAVE_COUNT(SAVE_COUNT)) u_csr_read_mux (
        .csr_re     (csr_re),
        .csr_num    (csr_num),
        .trap_regs  (trap_regs),
        .irq_regs   (irq_regs),
        .timer_regs (timer_regs),
        .save_data  (save_data),
        .csr_rvalue (csr_rvalue)
    );

endmodule

`default_nettype wire

//--- testbench/csr_top_asserts.sv
`default_nettype none
`timescale 1ns/1ps

module csr_top_asserts (
    input wire                               clk,
    input wire                               reset,
    input wire [1:0]                         plv,
    input wire                               trap_ex,
    input wire                               has_int,
    input wire [31:0]                        ertn_entry,
    input wire                               csr_re,
    input wire [csr_addr_pkg::CSR_NUM_W-1:0] csr_num,
    input wire [31:0]                        csr_rvalue
);
    import csr_addr_pkg::*;

    int fail_count = 0;

    int_needs_ie: assert property (@(posedge clk) disable iff (reset)
            csr_re && csr_num == CSR_CRMD && !csr_rvalue[CRMD_IE_BIT] |-> !has_int)
        else begin
            fail_count++;
            $error("has_int high while CRMD.ie is zero");
        end

    plv_after_ex: assert property (@(posedge clk) disable iff (reset) trap_ex |=> plv == 2'b0)
        else begin
            fail_count++;
            $error("plv not zero in the cycle after an exception");
        end

    ertn_is_era: assert property (@(posedge clk) disable iff (reset)
            csr_re && csr_num == CSR_ERA |-> ertn_entry === csr_rvalue)
        else begin
            fail_count++;
            $error("ertn_entry differs from ERA");
        end

    ticlr_reads_zero: assert property (@(posedge clk) disable iff (reset)
            csr_re && csr_num == CSR_TICLR |-> csr_rvalue == 32'b0)
        else begin
            fail_count++;
            $error("TICLR read returned a nonzero value");
        end

endmodule

bind csr_top csr_top_asserts u_asserts (
    .clk        (clk),
    .reset      (reset),
    .plv        (trap_regs.plv),
    .trap_ex    (trap.ex),
    .has_int    (has_int),
    .ertn_entry (ertn_entry),
    .csr_re     (csr_re),
    .csr_num    (csr_num),
    .csr_rvalue (csr_rvalue)
);

`default_nettype wire

//--- testbench/csr_top_tb.sv
`default_nettype none
`timescale 1ns/1ps

module csr_top_tb;
    import csr_addr_pkg::*;
    import csr_types_pkg::*;

    localparam int SAVE_COUNT = 4;
    localparam int WAIT_LIMIT = 200;

    logic                 clk;
    logic                 reset;
    csr_write_t           wr;
    logic                 csr_re;
    logic [CSR_NUM_W-1:0] csr_num;
    trap_event_t          trap;
    irq_lines_t           irq;
    wire [31:0]           csr_rvalue;
    wire                  has_int;
    wire [31:0]           ex_entry;
    wire [31:0]           ertn_entry;

    // Reference model state
    logic [1:0]  m_plv;
    logic        m_ie;
    logic [1:0]  m_pplv;
    logic        m_pie;
    logic [31:0] m_era;
    logic [5:0]  m_ecode;
    logic [8:0]  m_esub;
    logic [31:0] m_badv;
    logic [31:0] m_eentry;
    logic [12:0] m_lie;
    logic [12:0] m_is;
    logic        m_en;
    logic        m_per;
    logic [29:0] m_init;
    logic [31:0] m_tval;
    logic [31:0] m_save [SAVE_COUNT];

    logic [31:0] lfsr = 32'h1d29_d1b7;
    logic        chk_on = 1'b0;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          test_start = 0;

    csr_top #(.SAVE_COUNT(SAVE_COUNT)) u_csr_top (
        .clk        (clk),
        .reset      (reset),
        .wr         (wr),
        .csr_re     (csr_re),
        .csr_num    (csr_num),
        .trap       (trap),
        .irq        (irq),
        .csr_rvalue (csr_rvalue),
        .has_int    (has_int),
        .ex_entry   (ex_entry),
        .ertn_entry (ertn_entry)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hB4BC_D35C) : (s >> 1);
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = 32'b0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    function automatic logic [31:0] merge_ref(input logic [31:0] old, mask, value);
        return (old & ~mask) | (value & mask);
    endfunction

    function automatic logic [31:0] expected_read(input logic re,
                                                  input logic [CSR_NUM_W-1:0] num);
        logic [31:0] v;
        v = 32'b0;
        case (num)
            CSR_CRMD:   v = {28'b0, 1'b1, m_ie, m_plv};
            CSR_PRMD:   v = {29'b0, m_pie, m_pplv};
            CSR_ECFG:   v = {19'b0, m_lie};
            CSR_ESTAT:  v = {1'b0, m_esub, m_ecode, 3'b0, m_is};
            CSR_ERA:    v = m_era;
            CSR_BADV:   v = m_badv;
            CSR_EENTRY: v = m_eentry;
            CSR_TCFG:   v = {m_init, m_per, m_en};
            CSR_TVAL:   v = m_tval;
            default: begin
                if (num >= CSR_SAVE_BASE && num < CSR_SAVE_BASE + SAVE_COUNT)
                    v = m_save[num - CSR_SAVE_BASE];
            end
        endcase
        return re ? v : 32'b0;
    endfunction

    function automatic logic expected_has_int();
        return m_ie && (m_is & m_lie) != 13'b0;
    endfunction

    // Applies one clock edge to the model, from the inputs held at that edge
    task automatic model_edge();
        logic [31:0] merged;
        logic [31:0] tcfg_merged;
        logic        tcfg_wr;
        logic        zero_now;
        zero_now    = m_tval == 32'b0;
        tcfg_wr     = wr.we && wr.num == CSR_TCFG;
        tcfg_merged = merge_ref({m_init, m_per, m_en}, wr.wmask, wr.wvalue);
        if (reset) begin
            m_plv   = 2'b0;
            m_ie    = 1'b0;
            m_ecode = 6'b0;
            m_esub  = 9'b0;
            m_lie   = 13'b0;
            m_is    = 13'b0;
            m_en    = 1'b0;
            m_per   = 1'b0;
            m_init  = 30'b0;
            m_tval  = 32'hFFFF_FFFF;
        end else begin
            if (trap.ex) begin
                m_pplv  = m_plv;
                m_pie   = m_ie;
                m_plv   = 2'b0;
                m_ie    = 1'b0;
                m_era   = trap.pc;
                m_ecode = trap.ecode;
                m_esub  = trap.esubcode;
                if (trap.ecode == ECODE_ADE && trap.esubcode == ESUBCODE_ADEF)
                    m_badv = trap.pc;
                else if (trap.ecode == ECODE_ADE || trap.ecode == ECODE_ALE)
                    m_badv = trap.vaddr;
            end else if (trap.ertn) begin
                m_plv = m_pplv;
                m_ie  = m_pie;
            end else if (wr.we) begin
                case (wr.num)
                    CSR_CRMD: begin
                        merged = merge_ref({29'b0, m_ie, m_plv}, wr.wmask, wr.wvalue);
                        m_plv  = merged[1:0];
                        m_ie   = merged[2];
                    end
                    CSR_PRMD: begin
                        merged = merge_ref({29'b0, m_pie, m_pplv}, wr.wmask, wr.wvalue);
                        m_pplv = merged[1:0];
                        m_pie  = merged[2];
                    end
                    CSR_ERA:    m_era = merge_ref(m_era, wr.wmask, wr.wvalue);
                    CSR_EENTRY: m_eentry = merge_ref(m_eentry, wr.wmask, wr.wvalue) & ~32'h3F;
                    default: ;
                endcase
            end
            if (wr.we && wr.num == CSR_ECFG) begin
                merged = merge_ref({19'b0, m_lie}, wr.wmask, wr.wvalue);
                m_lie  = merged[12:0] & ECFG_LIE_MASK;
            end
            if (wr.we && wr.num == CSR_ESTAT) begin
                merged    = merge_ref({19'b0, m_is}, wr.wmask, wr.wvalue);
                m_is[1:0] = merged[1:0];
            end
            m_is[9:2] = irq.hw;
            m_is[10]  = 1'b0;
            if (zero_now)
                m_is[IRQ_TIMER] = 1'b1;
            else if (wr.we && wr.num == CSR_TICLR && wr.wmask[0] && wr.wvalue[0])
                m_is[IRQ_TIMER] = 1'b0;
            m_is[IRQ_IPI] = irq.ipi;
            if (tcfg_wr && tcfg_merged[0]) begin
                m_tval = {tcfg_merged[31:2], 2'b00};
            end else if (m_en && m_tval != 32'hFFFF_FFFF) begin
                if (zero_now && m_per)
                    m_tval = {m_init, 2'b00};
                else
                    m_tval = m_tval - 32'd1;
            end
            if (tcfg_wr) begin
                m_en   = tcfg_merged[0];
                m_per  = tcfg_merged[1];
                m_init = tcfg_merged[31:2];
            end
        end
        if (wr.we && wr.num >= CSR_SAVE_BASE && wr.num < CSR_SAVE_BASE + SAVE_COUNT)
            m_save[wr.num - CSR_SAVE_BASE] =
                merge_ref(m_save[wr.num - CSR_SAVE_BASE], wr.wmask, wr.wvalue);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual, expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("mismatch at %0t: %s got %08h expected %08h", $time, name, actual,
                     expected);
        end
    endtask

    // Compares the DUT against the model in the middle of every cycle
    always @(negedge clk) begin
        if (chk_on) begin
            check_value($sformatf("csr_rvalue[%03h]", csr_num), csr_rvalue,
                        expected_read(csr_re, csr_num));
            check_value("has_int", {31'b0, has_int}, {31'b0, expected_has_int()});
            check_value("ex_entry", ex_entry, m_eentry);
            check_value("ertn_entry", ertn_entry, m_era);
        end
    end

    task automatic step();
        @(posedge clk);
        model_edge();
        #1;
    endtask

    task automatic write_csr(input logic [CSR_NUM_W-1:0] num, input logic [31:0] mask, value);
        wr.we     = 1'b1;
        wr.num    = num;
        wr.wmask  = mask;
        wr.wvalue = value;
        step();
        wr = '0;
    endtask

    task automatic read_csr(input logic [CSR_NUM_W-1:0] num);
        csr_re  = 1'b1;
        csr_num = num;
        step();
    endtask

    task automatic wait_csr(input logic [CSR_NUM_W-1:0] num, input logic [31:0] mask, value,
                            input string what);
        int n;
        n       = 0;
        csr_re  = 1'b1;
        csr_num = num;
        do begin
            step();
            n++;
        end while ((csr_rvalue & mask) !== value && n < WAIT_LIMIT);
        if ((csr_rvalue & mask) !== value) begin
            errors++;
            $display("timeout after %0d cycles waiting for %s", n, what);
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %0d %s: %s (%0d errors)", tests, name,
                 (errors == test_start) ? "ok" : "bad", errors - test_start);
        test_start = errors;
    endtask

    initial begin
        logic [CSR_NUM_W-1:0] rw_list [$];
        logic [31:0]          v;
        logic [31:0]          mask;
        logic [31:0]          pc;
        logic [31:0]          va;
        logic [31:0]          sub;
        logic [31:0]          code;
        logic [29:0]          init;
        clk    = 1'b0;
        reset  = 1'b1;
        wr     = '0;
        csr_re = 1'b0;
        csr_num = '0;
        trap   = '0;
        irq    = '0;
        m_eentry = {26'bx, 6'b0}; // Low bits of EENTRY are always zero
        repeat (5) step();
        reset  = 1'b0;
        chk_on = 1'b1;

        for (int i = 0; i < SAVE_COUNT; i++)
            rw_list.push_back(CSR_NUM_W'(CSR_SAVE_BASE + i));
        rw_list.push_back(CSR_PRMD);
        rw_list.push_back(CSR_ERA);
        rw_list.push_back(CSR_EENTRY);
        rw_list.push_back(CSR_ECFG);
        foreach (rw_list[j]) begin
            rand_bits(32, v);
            write_csr(rw_list[j], 32'hFFFF_FFFF, v); // Unreset registers get a known value
            read_csr(rw_list[j]);
            repeat (3) begin
                rand_bits(32, mask);
                rand_bits(32, v);
                write_csr(rw_list[j], mask, v);
                read_csr(rw_list[j]);
            end
        end
        end_test("masked writes");

        for (int k = 0; k < 4; k++) begin
            rand_bits(3, v);
            write_csr(CSR_CRMD, 32'h7, v);
            rand_bits(32, pc);
            rand_bits(32, va);
            rand_bits(9, sub);
            rand_bits(6, code);
            case (k)
                0: begin
                    code = ECODE_ADE;
                    sub  = ESUBCODE_ADEF;
                end
                1: code = ECODE_ALE;
                2: begin
                    code = ECODE_ADE;
                    sub  = sub | 32'h1; // Not a fetch fault
                end
                default: begin
                    if (code == ECODE_ADE || code == ECODE_ALE)
                        code = 32'h0B;
                end
            endcase
            trap = '{ex: 1'b1, ertn: 1'b0, pc: pc, ecode: code[5:0], esubcode: sub[8:0],
                     vaddr: va};
            step();
            trap = '0;
            read_csr(CSR_CRMD);
            read_csr(CSR_PRMD);
            read_csr(CSR_ERA);
            read_csr(CSR_ESTAT);
            read_csr(CSR_BADV);
        end
        end_test("exception entry");

        for (int k = 0; k < 4; k++) begin
            if (k > 0) begin
                rand_bits(3, v);
                write_csr(CSR_PRMD, 32'h7, v);
                rand_bits(32, v);
                write_csr(CSR_ERA, 32'hFFFF_FFFF, v);
            end
            trap.ertn = 1'b1;
            step();
            trap = '0;
            read_csr(CSR_CRMD);
            read_csr(CSR_ERA);
        end
        end_test("exception return");

        repeat (10) begin
            rand_bits(13, v);
            write_csr(CSR_ECFG, 32'hFFFF_FFFF, v);
            rand_bits(2, v);
            write_csr(CSR_ESTAT, 32'h3, v);
            rand_bits(1, v);
            write_csr(CSR_CRMD, 32'h4, {29'b0, v[0], 2'b0});
            rand_bits(9, v);
            irq = irq_lines_t'(v[8:0]);
            step(); // Lines reach ESTAT
            read_csr(CSR_ESTAT);
            read_csr(CSR_CRMD);
        end
        irq = '0;
        write_csr(CSR_ESTAT, 32'h3, 32'h0);
        end_test("interrupts");

        write_csr(CSR_ECFG, 32'hFFFF_FFFF, 32'h1 << IRQ_TIMER);
        write_csr(CSR_CRMD, 32'h4, 32'h4);
        rand_bits(3, v);
        init = 30'd4 + v[29:0];
        write_csr(CSR_TCFG, 32'hFFFF_FFFF, {init, 1'b0, 1'b1});
        repeat (6) read_csr(CSR_TVAL); // First read is the loaded value
        wait_csr(CSR_ESTAT, 32'h1 << IRQ_TIMER, 32'h1 << IRQ_TIMER, "one-shot timer bit");
        write_csr(CSR_TICLR, 32'h1, 32'h1);
        read_csr(CSR_ESTAT);
        read_csr(CSR_TICLR);
        wait_csr(CSR_TVAL, 32'hFFFF_FFFF, 32'hFFFF_FFFF, "TVAL to stop at all ones");
        read_csr(CSR_TCFG);
        end_test("one-shot timer");

        rand_bits(3, v);
        init = 30'd4 + v[29:0];
        write_csr(CSR_TCFG, 32'hFFFF_FFFF, {init, 1'b1, 1'b1});
        wait_csr(CSR_ESTAT, 32'h1 << IRQ_TIMER, 32'h1 << IRQ_TIMER, "periodic timer bit");
        csr_num = CSR_TVAL;
        @(negedge clk);
        check_value("csr_rvalue[TVAL] reload", csr_rvalue, {init, 2'b00});
        step();
        write_csr(CSR_TICLR, 32'h1, 32'h1);
        read_csr(CSR_ESTAT);
        wait_csr(CSR_ESTAT, 32'h1 << IRQ_TIMER, 32'h1 << IRQ_TIMER, "second timer period");
        read_csr(CSR_TVAL);
        write_csr(CSR_TCFG, 32'hFFFF_FFFF, 32'h0);
        read_csr(CSR_TVAL);
        csr_re = 1'b0; // Disabled reads give zero
        read_csr(CSR_ERA);
        end_test("periodic timer");

        step();
        chk_on = 1'b0;
        errors = errors + u_csr_top.u_asserts.fail_count;
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- csr_top.f
logic/csr_addr_pkg.sv
logic/csr_types_pkg.sv
logic/trap_state.sv
logic/interrupt_ctrl.sv
logic/stable_timer.sv
logic/save_regs.sv
logic/csr_read_mux.sv
logic/csr_top.sv
testbench/csr_top_asserts.sv
testbench/csr_top_tb.sv

//--- Bender.yml
package:
  name: csr_top

sources:
  - files:
      - logic/csr_addr_pkg.sv
      - logic/csr_types_pkg.sv
      - logic/trap_state.sv
      - logic/interrupt_ctrl.sv
      - logic/stable_timer.sv
      - logic/save_regs.sv
      - logic/csr_read_mux.sv
      - logic/csr_top.sv
  - target: test
    files:
      - testbench/csr_top_asserts.sv
      - testbench/csr_top_tb.sv
